// ==== verilog/coherence_pkg.sv ====
// Shared constants and types for the two-CPU MESI snooping subsystem.
// Every RTL file refers to these by scoped names.
package coherence_pkg;

    localparam int N_CPUS = 2;
    localparam int N_LINES = 8;                    // Direct-mapped lines per CPU
    localparam int IDX_W = $clog2(N_LINES);
    localparam int TAG_W = 30 - IDX_W;
    localparam logic [31:0] NONCACHE_START = 32'hF000_0000;
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW = $clog2(MEM_WORDS);     // Word address bits into memory

    typedef enum logic [1:0] {
        MODIFIED,
        EXCLUSIVE,
        SHARED,
        INVALID
    } mesi_t;

    // Cache address, seen as a raw word or split into its fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TAG_W-1:0] tag;
            logic [IDX_W-1:0] index;
            logic [1:0]       offset;
        } fields;
    } cache_addr_u;

    typedef struct packed {
        logic        ren;
        logic        wen;
        cache_addr_u addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        busy;
        logic [31:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic        dren;
        logic        dwen;
        logic        ccwrite;   // Read for ownership or upgrade
        logic [31:0] daddr;
        logic [31:0] dstore;
    } bus_req_t;

    typedef struct packed {
        logic        dwait;
        logic [31:0] dload;
        logic        ccexclusive;
        logic        ccwait;
        logic        ccinv;
        logic [31:0] ccsnoopaddr;
    } bus_rsp_t;

    typedef struct packed {
        logic        ccsnoopdone;
        logic        ccsnoophit;
        logic        ccdirty;
        logic [31:0] snoopdata;
    } snoop_rsp_t;

    typedef struct packed {
        logic [15:0] to_e_transitions;
        logic [15:0] to_s_transitions;
        logic [15:0] shared_blocks;
        logic [15:0] invalidated_blocks;
    } coherence_stats_t;

endpackage

// ==== verilog/mesi_line_store.sv ====
// Per-CPU direct-mapped write-back cache of one-word lines.
// Serves hits combinationally and hands misses to the coherency unit,
// which installs fills and changes state on snoops.
`timescale 1ns/100ps

module mesi_line_store (
    input  logic                         CLK,
    input  logic                         nRST,
    input  coherence_pkg::cpu_req_t      cpu_req,
    input  logic                         fill_done,
    input  coherence_pkg::mesi_t         fill_state,
    input  logic [31:0]                  fill_data,
    input  coherence_pkg::cache_addr_u   snoop_addr,
    input  coherence_pkg::mesi_t         snoop_set_state,
    input  logic                         snoop_update,
    output coherence_pkg::cpu_rsp_t      cpu_rsp,
    output logic                         miss_req,
    output logic                         miss_write,
    output logic                         victim_dirty,
    output logic [31:0]                  victim_addr,
    output logic [31:0]                  victim_data,
    output logic                         snoop_hit,
    output coherence_pkg::mesi_t         snoop_state,
    output logic [31:0]                  snoop_data
);
    logic [coherence_pkg::TAG_W-1:0] tags [coherence_pkg::N_LINES];
    logic [31:0]                     lines [coherence_pkg::N_LINES];
    coherence_pkg::mesi_t            states [coherence_pkg::N_LINES];

    logic [coherence_pkg::IDX_W-1:0] idx, sidx;
    logic uncached, tag_hit, writable, rd_hit, wr_hit;

    assign idx = cpu_req.addr.fields.index;
    assign sidx = snoop_addr.fields.index;
    assign uncached = cpu_req.addr.raw >= coherence_pkg::NONCACHE_START;
    assign tag_hit = !uncached && states[idx] != coherence_pkg::INVALID
                     && tags[idx] == cpu_req.addr.fields.tag;
    assign writable = states[idx] == coherence_pkg::MODIFIED
                      || states[idx] == coherence_pkg::EXCLUSIVE;
    assign rd_hit = cpu_req.ren && tag_hit;
    assign wr_hit = cpu_req.wen && tag_hit && writable;   // S needs an upgrade

    assign miss_req = (cpu_req.ren || cpu_req.wen) && !(rd_hit || wr_hit);
    assign miss_write = cpu_req.wen;
    assign victim_dirty = !uncached && states[idx] == coherence_pkg::MODIFIED
                          && tags[idx] != cpu_req.addr.fields.tag;
    assign victim_addr = {tags[idx], idx, 2'b00};
    assign victim_data = lines[idx];

    assign cpu_rsp.busy = miss_req && !fill_done;
    assign cpu_rsp.rdata = (rd_hit || wr_hit) ? lines[idx] : fill_data;

    // Snoop lookup port
    assign snoop_hit = states[sidx] != coherence_pkg::INVALID
                       && tags[sidx] == snoop_addr.fields.tag;
    assign snoop_state = states[sidx];
    assign snoop_data = lines[sidx];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < coherence_pkg::N_LINES; i++) begin
                states[i] <= coherence_pkg::INVALID;
            end
        end else begin
            if (fill_done && !uncached) begin
                states[idx] <= fill_state;
            end else if (wr_hit) begin
                states[idx] <= coherence_pkg::MODIFIED;   // Silent E to M
            end
            if (snoop_update) begin
                states[sidx] <= snoop_set_state;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_done && !uncached) begin
            tags[idx] <= cpu_req.addr.fields.tag;
            lines[idx] <= cpu_req.wen ? cpu_req.wdata : fill_data;
        end else if (wr_hit) begin
            lines[idx] <= cpu_req.wdata;
        end
    end

endmodule

// ==== verilog/coherency_unit.sv ====
// Per-CPU MESI controller. Turns cache misses, upgrades, dirty evictions
// and uncached accesses into bus transactions, answers snoops from the
// other CPU and keeps the coherence statistics counters.
`timescale 1ns/100ps

module coherency_unit (
    input  logic                           CLK,
    input  logic                           nRST,
    input  coherence_pkg::cpu_req_t        cpu_req,
    input  logic                           miss_req,
    input  logic                           miss_write,
    input  logic                           victim_dirty,
    input  logic [31:0]                    victim_addr,
    input  logic [31:0]                    victim_data,
    input  logic                           snoop_hit,
    input  coherence_pkg::mesi_t           snoop_state,
    input  logic [31:0]                    snoop_data,
    input  coherence_pkg::bus_rsp_t        bus_rsp,
    output logic                           fill_done,
    output coherence_pkg::mesi_t           fill_state,
    output logic [31:0]                    fill_data,
    output coherence_pkg::cache_addr_u     snoop_addr,
    output coherence_pkg::mesi_t           snoop_set_state,
    output logic                           snoop_update,
    output coherence_pkg::bus_req_t        bus_req,
    output coherence_pkg::snoop_rsp_t      snoop_rsp,
    output coherence_pkg::coherence_stats_t coherence_statistics
);
    typedef enum logic [2:0] {
        IDLE, WRITE_REQ, READ_REQ, RESP_CHKTAG, RESP_SEND, RESP_FAIL, WRITEBACK
    } state_t;

    state_t state, next_state;
    coherence_pkg::coherence_stats_t next_stats;
    logic pass_through;
    logic wb_done;   // Victim already written back for the pending miss

    assign pass_through = cpu_req.addr.raw >= coherence_pkg::NONCACHE_START
                          && (cpu_req.ren || cpu_req.wen);
    assign snoop_addr.raw = bus_rsp.ccsnoopaddr;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            wb_done <= 1'b0;
            coherence_statistics <= '0;
        end else begin
            state <= next_state;
            coherence_statistics <= next_stats;
            if (fill_done) begin
                wb_done <= 1'b0;
            end else if (state == WRITEBACK && !bus_rsp.dwait && !pass_through) begin
                wb_done <= 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (bus_rsp.ccwait) begin
                    next_state = RESP_CHKTAG;   // Snoops come first
                end else if (miss_req && (pass_through || (victim_dirty && !wb_done))) begin
                    next_state = WRITEBACK;
                end else if (miss_req) begin
                    next_state = miss_write ? WRITE_REQ : READ_REQ;
                end
            end
            WRITE_REQ, READ_REQ, WRITEBACK: begin
                if (bus_rsp.ccwait) begin
                    next_state = RESP_CHKTAG;
                end else if (!bus_rsp.dwait) begin
                    next_state = IDLE;
                end
            end
            RESP_CHKTAG: next_state = snoop_hit ? RESP_SEND : RESP_FAIL;
            RESP_SEND, RESP_FAIL: begin
                if (!bus_rsp.ccwait) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        next_stats = coherence_statistics;
        fill_done = 1'b0;
        fill_state = coherence_pkg::INVALID;
        fill_data = bus_rsp.dload;
        snoop_set_state = bus_rsp.ccinv ? coherence_pkg::INVALID : coherence_pkg::SHARED;
        snoop_update = 1'b0;
        bus_req = '0;
        bus_req.daddr = cpu_req.addr.raw;
        bus_req.dstore = cpu_req.wdata;
        snoop_rsp = '0;
        case (state)
            RESP_CHKTAG: snoop_rsp.ccsnoopdone = !snoop_hit;   // Misses answer at once
            RESP_SEND: begin
                snoop_rsp.ccsnoopdone = 1'b1;
                snoop_rsp.ccsnoophit = 1'b1;
                snoop_rsp.ccdirty = snoop_state == coherence_pkg::MODIFIED;
                snoop_rsp.snoopdata = snoop_data;
                if (!bus_rsp.ccwait) begin
                    snoop_update = 1'b1;
                    if (bus_rsp.ccinv) begin
                        next_stats.invalidated_blocks = coherence_statistics.invalidated_blocks
                                                        + 16'd1;
                    end else if (snoop_state != coherence_pkg::SHARED) begin
                        next_stats.shared_blocks = coherence_statistics.shared_blocks + 16'd1;
                    end
                end
            end
            RESP_FAIL: snoop_rsp.ccsnoopdone = 1'b1;
            READ_REQ: begin
                bus_req.dren = 1'b1;
                fill_done = !bus_rsp.dwait;
                fill_state = bus_rsp.ccexclusive ? coherence_pkg::EXCLUSIVE
                                                 : coherence_pkg::SHARED;
                if (!bus_rsp.dwait && bus_rsp.ccexclusive) begin
                    next_stats.to_e_transitions = coherence_statistics.to_e_transitions + 16'd1;
                end else if (!bus_rsp.dwait) begin
                    next_stats.to_s_transitions = coherence_statistics.to_s_transitions + 16'd1;
                end
            end
            WRITE_REQ: begin
                bus_req.dren = 1'b1;
                bus_req.ccwrite = 1'b1;
                fill_done = !bus_rsp.dwait;
                fill_state = coherence_pkg::MODIFIED;
            end
            WRITEBACK: begin
                if (pass_through) begin
                    bus_req.dren = cpu_req.ren;
                    bus_req.dwen = cpu_req.wen;
                    fill_done = !bus_rsp.dwait;   // Line store skips the install
                end else begin
                    bus_req.dwen = 1'b1;
                    bus_req.daddr = victim_addr;
                    bus_req.dstore = victim_data;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/snoop_bus_ctrl.sv ====
// Snoop bus controller. Grants one CPU at a time round-robin, snoops the
// other CPU on cached reads and ownership requests, then completes the
// transaction against the backing memory.
`timescale 1ns/100ps

module snoop_bus_ctrl (
    input  logic                      CLK,
    input  logic                      nRST,
    input  coherence_pkg::bus_req_t   bus_req [coherence_pkg::N_CPUS],
    input  coherence_pkg::snoop_rsp_t snoop_rsp [coherence_pkg::N_CPUS],
    input  logic [31:0]               mem_rdata,
    input  logic                      mem_valid,
    output coherence_pkg::bus_rsp_t   bus_rsp [coherence_pkg::N_CPUS],
    output logic                      mem_en,
    output logic                      mem_we,
    output logic [31:0]               mem_addr,
    output logic [31:0]               mem_wdata
);
    typedef enum logic [1:0] {ARB, SNOOP, MEM_REQ, MEM_WAIT} state_t;

    state_t state;
    logic gnt, prio, peer, next_gnt;
    logic hit_q, dirty_q;
    logic [31:0] snoop_data_q;
    logic [coherence_pkg::N_CPUS-1:0] pending;
    logic needs_snoop;
    coherence_pkg::bus_req_t req;

    always_comb begin
        for (int i = 0; i < coherence_pkg::N_CPUS; i++) begin
            pending[i] = bus_req[i].dren || bus_req[i].dwen;
        end
    end

    assign next_gnt = pending[prio] ? prio : ~prio;
    assign needs_snoop = bus_req[next_gnt].ccwrite || (bus_req[next_gnt].dren
                         && bus_req[next_gnt].daddr < coherence_pkg::NONCACHE_START);
    assign peer = ~gnt;
    assign req = bus_req[gnt];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= ARB;
            gnt <= 1'b0;
            prio <= 1'b0;
            hit_q <= 1'b0;
            dirty_q <= 1'b0;
        end else begin
            case (state)
                ARB: begin
                    hit_q <= 1'b0;
                    dirty_q <= 1'b0;
                    if (|pending) begin
                        gnt <= next_gnt;
                        state <= needs_snoop ? SNOOP : MEM_REQ;
                    end
                end
                SNOOP: begin
                    if (snoop_rsp[peer].ccsnoopdone) begin
                        hit_q <= snoop_rsp[peer].ccsnoophit;
                        dirty_q <= snoop_rsp[peer].ccdirty;
                        state <= MEM_REQ;
                    end
                end
                MEM_REQ: state <= MEM_WAIT;
                MEM_WAIT: begin
                    if (mem_valid) begin
                        prio <= ~gnt;   // Other CPU goes first next time
                        state <= ARB;
                    end
                end
                default: state <= ARB;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == SNOOP && snoop_rsp[peer].ccsnoopdone) begin
            snoop_data_q <= snoop_rsp[peer].snoopdata;
        end
    end

    // Dirty supplied data is written back while the requester is served
    assign mem_en = state == MEM_REQ;
    assign mem_we = req.dwen || (hit_q && dirty_q);
    assign mem_addr = req.daddr;
    assign mem_wdata = (hit_q && dirty_q) ? snoop_data_q : req.dstore;

    always_comb begin
        for (int i = 0; i < coherence_pkg::N_CPUS; i++) begin
            bus_rsp[i].dwait = !(state == MEM_WAIT && mem_valid && gnt == 1'(i));
            bus_rsp[i].dload = hit_q ? snoop_data_q : mem_rdata;
            bus_rsp[i].ccexclusive = !hit_q;
            bus_rsp[i].ccwait = state == SNOOP && peer == 1'(i);
            bus_rsp[i].ccinv = req.ccwrite;
            bus_rsp[i].ccsnoopaddr = req.daddr;
        end
    end

endmodule

// ==== verilog/backing_memory.sv ====
// Word-addressed backing memory behind the snoop bus controller.
// Answers every access exactly two cycles after mem_en.
`timescale 1ns/100ps

module backing_memory (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        mem_en,
    input  logic        mem_we,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic [31:0] mem_rdata,
    output logic        mem_valid
);
    logic [31:0] words [coherence_pkg::MEM_WORDS];
    logic [coherence_pkg::MEM_AW-1:0] waddr;
    logic        valid_q;
    logic [31:0] rdata_q;

    assign waddr = mem_addr[coherence_pkg::MEM_AW+1:2];   // Wraps modulo the size

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < coherence_pkg::MEM_WORDS; i++) begin
                words[i] <= '0;
            end
            valid_q <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            valid_q <= mem_en;
            mem_valid <= valid_q;
            if (mem_en && mem_we) begin
                words[waddr] <= mem_wdata;
            end
        end
    end

    always_ff @(posedge CLK) begin
        rdata_q <= words[waddr];
        mem_rdata <= rdata_q;
    end

endmodule

// ==== verilog/coherent_pair_top.sv ====
// Top level of the two-CPU coherent subsystem: one line store and one
// coherency unit per CPU, the snoop bus controller and the memory.
`timescale 1ns/100ps

module coherent_pair_top (
    input  logic                             CLK,
    input  logic                             nRST,
    input  coherence_pkg::cpu_req_t          cpu_req [coherence_pkg::N_CPUS],
    output coherence_pkg::cpu_rsp_t          cpu_rsp [coherence_pkg::N_CPUS],
    output coherence_pkg::coherence_stats_t  coherence_statistics [coherence_pkg::N_CPUS]
);
    localparam int N = coherence_pkg::N_CPUS;

    logic                       miss_req [N], miss_write [N], victim_dirty [N];
    logic [31:0]                victim_addr [N], victim_data [N];
    logic                       snoop_hit [N], snoop_update [N], fill_done [N];
    logic [31:0]                snoop_data [N], fill_data [N];
    coherence_pkg::mesi_t       snoop_state [N], fill_state [N], snoop_set_state [N];
    coherence_pkg::cache_addr_u snoop_addr [N];
    coherence_pkg::bus_req_t    bus_req [N];
    coherence_pkg::bus_rsp_t    bus_rsp [N];
    coherence_pkg::snoop_rsp_t  snoop_rsp [N];
    logic                       mem_en, mem_we, mem_valid;
    logic [31:0]                mem_addr, mem_wdata, mem_rdata;

    for (genvar i = 0; i < N; i++) begin : g_cpu
        mesi_line_store line_store_inst (
            .CLK(CLK), .nRST(nRST), .cpu_req(cpu_req[i]), .cpu_rsp(cpu_rsp[i]),
            .fill_done(fill_done[i]), .fill_state(fill_state[i]),
            .fill_data(fill_data[i]), .snoop_addr(snoop_addr[i]),
            .snoop_set_state(snoop_set_state[i]), .snoop_update(snoop_update[i]),
            .miss_req(miss_req[i]), .miss_write(miss_write[i]),
            .victim_dirty(victim_dirty[i]), .victim_addr(victim_addr[i]),
            .victim_data(victim_data[i]), .snoop_hit(snoop_hit[i]),
            .snoop_state(snoop_state[i]), .snoop_data(snoop_data[i])
        );

        coherency_unit unit_inst (
            .CLK(CLK), .nRST(nRST), .cpu_req(cpu_req[i]),
            .miss_req(miss_req[i]), .miss_write(miss_write[i]),
            .victim_dirty(victim_dirty[i]), .victim_addr(victim_addr[i]),
            .victim_data(victim_data[i]), .snoop_hit(snoop_hit[i]),
            .snoop_state(snoop_state[i]), .snoop_data(snoop_data[i]),
            .bus_rsp(bus_rsp[i]), .fill_done(fill_done[i]),
            .fill_state(fill_state[i]), .fill_data(fill_data[i]),
            .snoop_addr(snoop_addr[i]), .snoop_set_state(snoop_set_state[i]),
            .snoop_update(snoop_update[i]), .bus_req(bus_req[i]),
            .snoop_rsp(snoop_rsp[i]), .coherence_statistics(coherence_statistics[i])
        );
    end

    snoop_bus_ctrl bus_ctrl_inst (
        .CLK(CLK), .nRST(nRST), .bus_req(bus_req), .snoop_rsp(snoop_rsp),
        .mem_rdata(mem_rdata), .mem_valid(mem_valid), .bus_rsp(bus_rsp),
        .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    backing_memory memory_inst (
        .CLK(CLK), .nRST(nRST), .mem_en(mem_en), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_valid(mem_valid)
    );

endmodule

// ==== tests/tb_coherence.sv ====
// Testbench for the two-CPU MESI subsystem. Issues one random access at a
// time from either CPU over a small address pool, then checks hit latency,
// read data and both CPUs' statistics counters against a golden memory and MESI model.
`timescale 1ns/100ps

module tb_coherence;
    localparam int N_ACCESSES = 300;
    localparam int CYCLES_PER_ACCESS = 20;
    localparam int CYCLE_LIMIT = N_ACCESSES * CYCLES_PER_ACCESS + 20;   // Plus reset margin
    localparam int POOL_SIZE = 10;
    // Lines 0..2 collide on their index, the last two bypass the caches
    localparam logic [31:0] ADDR_POOL [POOL_SIZE] = '{
        32'h0000_0000, 32'h0000_0020, 32'h0000_0040, 32'h0000_0004, 32'h0000_0024,
        32'h0000_0008, 32'h0000_000C, 32'h0000_002C, 32'hF000_0200, 32'hF000_0204
    };

    typedef struct packed {
        logic                    cpu;
        logic                    is_read;
        coherence_pkg::cpu_rsp_t got;
        coherence_pkg::cpu_rsp_t want;
    } done_t;

    logic CLK;
    logic nRST;
    coherence_pkg::cpu_req_t         cpu_req [coherence_pkg::N_CPUS];
    coherence_pkg::cpu_rsp_t         cpu_rsp [coherence_pkg::N_CPUS];
    coherence_pkg::coherence_stats_t coherence_statistics [coherence_pkg::N_CPUS];

    logic [31:0]                     gold_mem [coherence_pkg::MEM_WORDS];
    coherence_pkg::mesi_t            model_state [coherence_pkg::N_CPUS][coherence_pkg::N_LINES];
    logic [coherence_pkg::TAG_W-1:0] model_tag [coherence_pkg::N_CPUS][coherence_pkg::N_LINES];
    coherence_pkg::coherence_stats_t exp_stats [coherence_pkg::N_CPUS];
    done_t                           done_q [$];
    integer                          seed;
    int                              cycle_count;
    int                              checks_done;

    coherent_pair_top coherent_pair_top_inst (
        .CLK(CLK), .nRST(nRST), .cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
        .coherence_statistics(coherence_statistics)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_rsp(input string name, input coherence_pkg::cpu_rsp_t got,
                               input coherence_pkg::cpu_rsp_t want, input logic check_data);
        if (got.busy !== want.busy) begin
            abort_run($sformatf("** Error: %s.busy = %h, expected %h",
                                name, got.busy, want.busy));
        end
        if (check_data && got.rdata !== want.rdata) begin
            abort_run($sformatf("** Error: %s.rdata = %h, expected %h",
                                name, got.rdata, want.rdata));
        end
    endtask

    task automatic compare_stats(input string name, input coherence_pkg::coherence_stats_t got,
                                 input coherence_pkg::coherence_stats_t want);
        if (got.to_e_transitions !== want.to_e_transitions) begin
            abort_run($sformatf("** Error: %s.to_e_transitions = %h, expected %h",
                                name, got.to_e_transitions, want.to_e_transitions));
        end
        if (got.to_s_transitions !== want.to_s_transitions) begin
            abort_run($sformatf("** Error: %s.to_s_transitions = %h, expected %h",
                                name, got.to_s_transitions, want.to_s_transitions));
        end
        if (got.shared_blocks !== want.shared_blocks) begin
            abort_run($sformatf("** Error: %s.shared_blocks = %h, expected %h",
                                name, got.shared_blocks, want.shared_blocks));
        end
        if (got.invalidated_blocks !== want.invalidated_blocks) begin
            abort_run($sformatf("** Error: %s.invalidated_blocks = %h, expected %h",
                                name, got.invalidated_blocks, want.invalidated_blocks));
        end
    endtask

    // Golden model of one access: coherent memory view plus MESI table per CPU
    function automatic coherence_pkg::cpu_rsp_t predict_access(input logic cpu,
            input logic is_write, input coherence_pkg::cache_addr_u addr,
            input logic [31:0] wdata);
        coherence_pkg::cpu_rsp_t          want;
        logic                             peer;
        logic [coherence_pkg::IDX_W-1:0]  idx;
        logic [coherence_pkg::TAG_W-1:0]  tag;
        logic [coherence_pkg::MEM_AW-1:0] word;
        logic                             own_hit;
        logic                             peer_hit;
        logic                             local_hit;
        peer = ~cpu;
        idx = addr.fields.index;
        tag = addr.fields.tag;
        word = addr.raw[coherence_pkg::MEM_AW+1:2];   // Memory wraps on its size
        own_hit = model_state[cpu][idx] != coherence_pkg::INVALID && model_tag[cpu][idx] == tag;
        peer_hit = model_state[peer][idx] != coherence_pkg::INVALID
                   && model_tag[peer][idx] == tag;
        // Reads hit in M, E or S, writes only in M or E
        local_hit = addr.raw < coherence_pkg::NONCACHE_START && own_hit
                    && !(is_write && model_state[cpu][idx] == coherence_pkg::SHARED);
        if (addr.raw < coherence_pkg::NONCACHE_START) begin
            if (is_write && !(own_hit && model_state[cpu][idx] != coherence_pkg::SHARED)) begin
                if (peer_hit) begin   // Ownership request kills the peer copy
                    model_state[peer][idx] = coherence_pkg::INVALID;
                    exp_stats[peer].invalidated_blocks += 16'd1;
                end
            end else if (!is_write && !own_hit) begin
                if (peer_hit && model_state[peer][idx] != coherence_pkg::SHARED) begin
                    exp_stats[peer].shared_blocks += 16'd1;
                end
                if (peer_hit) begin
                    model_state[peer][idx] = coherence_pkg::SHARED;
                    exp_stats[cpu].to_s_transitions += 16'd1;
                end else begin
                    exp_stats[cpu].to_e_transitions += 16'd1;
                end
            end
            if (is_write) begin
                model_state[cpu][idx] = coherence_pkg::MODIFIED;
            end else if (!own_hit) begin
                model_state[cpu][idx] = peer_hit ? coherence_pkg::SHARED : coherence_pkg::EXCLUSIVE;
            end
            model_tag[cpu][idx] = tag;
        end
        if (is_write) begin
            gold_mem[word] = wdata;
        end
        want.busy = !local_hit;   // Busy in the request cycle
        want.rdata = gold_mem[word];
        return want;
    endfunction

    // Stimulus
    initial begin
        logic        cpu;
        logic        is_write;
        logic        first_busy;
        logic [31:0] rnd;
        logic [31:0] wdata;
        int          pool_idx;
        done_t       rec;
        seed = 32'hd608_63c6;
        checks_done = 0;
        nRST = 1'b0;
        for (int i = 0; i < coherence_pkg::N_CPUS; i++) begin
            cpu_req[i] = '0;
            exp_stats[i] = '0;
            for (int j = 0; j < coherence_pkg::N_LINES; j++) begin
                model_state[i][j] = coherence_pkg::INVALID;
                model_tag[i][j] = '0;
            end
        end
        for (int i = 0; i < coherence_pkg::MEM_WORDS; i++) begin
            gold_mem[i] = '0;
        end
        repeat (3) @(posedge CLK);
        #1 nRST = 1'b1;
        @(negedge CLK);
        for (int i = 0; i < coherence_pkg::N_CPUS; i++) begin   // Idle after reset
            compare_rsp($sformatf("cpu_rsp[%0d]", i), cpu_rsp[i], '0, 1'b0);
            compare_stats($sformatf("coherence_statistics[%0d]", i),
                          coherence_statistics[i], '0);
        end
        for (int n = 0; n < N_ACCESSES; n++) begin
            @(posedge CLK);
            #1;
            rnd = $random(seed);
            cpu = rnd[0];
            rnd = $random(seed);
            pool_idx = int'(rnd % 32'd10);
            rnd = $random(seed);
            is_write = rnd[0];
            wdata = $random(seed);
            cpu_req[cpu].ren = !is_write;
            cpu_req[cpu].wen = is_write;
            cpu_req[cpu].addr.raw = ADDR_POOL[pool_idx];
            cpu_req[cpu].wdata = wdata;
            @(negedge CLK);
            first_busy = cpu_rsp[cpu].busy;   // Hits finish in the request cycle
            while (cpu_rsp[cpu].busy) @(negedge CLK);
            rec.cpu = cpu;
            rec.is_read = !is_write;
            rec.got = cpu_rsp[cpu];
            rec.got.busy = first_busy;
            rec.want = predict_access(cpu, is_write, cpu_req[cpu].addr, wdata);
            @(posedge CLK);
            #1 cpu_req[cpu] = '0;
            done_q.push_back(rec);
        end
        repeat (2) @(posedge CLK);
        if (checks_done == N_ACCESSES) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("Not every access reached the compare process");
        end
    end

    // Compare, mid-cycle where DUT outputs and counters are settled
    initial begin
        done_t rec;
        forever begin
            @(negedge CLK);
            while (done_q.size() > 0) begin
                rec = done_q.pop_front();
                compare_rsp($sformatf("cpu_rsp[%0d]", rec.cpu), rec.got, rec.want, rec.is_read);
                for (int i = 0; i < coherence_pkg::N_CPUS; i++) begin
                    compare_stats($sformatf("coherence_statistics[%0d]", i),
                                  coherence_statistics[i], exp_stats[i]);
                end
                checks_done++;
            end
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge CLK);
            cycle_count++;
            if (cycle_count >= CYCLE_LIMIT) begin
                abort_run("Timeout: the accesses did not finish within the cycle limit");
            end
        end
    end

endmodule

// ==== files.f ====
verilog/coherence_pkg.sv
verilog/mesi_line_store.sv
verilog/coherency_unit.sv
verilog/snoop_bus_ctrl.sv
verilog/backing_memory.sv
verilog/coherent_pair_top.sv
tests/tb_coherence.sv

// ==== Makefile ====
# Verilator flow for the coherent pair testbench
VERILATOR ?= verilator
TOP       ?= tb_coherence
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
